// File: Makefile
TOP := llc_tb

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

build:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: design/llc_core.sv
/* write-back last-level cache core
   input decoder, tag store with lookup and control, output registers */
module llc_core
    import llc_pkg::*;
#(
    parameter int SETS = LLC_SETS,
    parameter int WAYS = LLC_WAYS
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         req_valid_i,
    input  llc_req_t     req_i,
    output logic         req_ready_o,
    output logic         rsp_valid_o,
    input  logic         rsp_ready_i,
    output llc_word_t    rsp_data_o,
    output logic         mem_req_valid_o,
    input  logic         mem_req_ready_i,
    output llc_mem_req_t mem_req_o,
    input  logic         mem_rsp_valid_i,
    input  llc_word_t    mem_rsp_data_i,
    output logic         mem_rsp_ready_o
);

    llc_req_t                    held_req;
    logic                        start;
    logic                        rsp_done;
    logic                        mem_busy;
    logic                        rd_en;
    logic                        wr_en;
    llc_way_t                    wr_way;
    llc_tag_t                    wr_tag;
    llc_line_state_t             wr_state;
    llc_word_t                   wr_data;
    logic                        adv_evict;
    llc_tag_t        [WAYS-1:0]  set_tags;
    llc_line_state_t [WAYS-1:0]  set_states;
    llc_word_t       [WAYS-1:0]  set_lines;
    llc_way_t                    evict_way;
    logic                        hit;
    llc_way_t                    hit_way;
    llc_way_t                    victim_way;
    logic                        victim_dirty;
    logic                        send_rsp;
    llc_word_t                   rsp_data;
    logic                        send_mem;
    llc_mem_req_t                mem_req;

    llc_input_decoder input_decoder_u (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .done_i      (rsp_done),
        .held_req_o  (held_req),
        .start_o     (start)
    );

    llc_tag_store #(
        .SETS (SETS),
        .WAYS (WAYS)
    ) tag_store_u (
        .clk         (clk),
        .rst         (rst),
        .rd_set_i    (held_req.addr.f.set),
        .rd_en_i     (rd_en),
        .wr_en_i     (wr_en),
        .wr_way_i    (wr_way),
        .wr_tag_i    (wr_tag),
        .wr_state_i  (wr_state),
        .wr_data_i   (wr_data),
        .adv_evict_i (adv_evict),
        .tags_o      (set_tags),
        .states_o    (set_states),
        .lines_o     (set_lines),
        .evict_way_o (evict_way)
    );

    llc_lookup_way #(
        .WAYS (WAYS)
    ) lookup_way_u (
        .tag_i          (held_req.addr.f.tag),
        .tags_i         (set_tags),
        .states_i       (set_states),
        .evict_way_i    (evict_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

    llc_process_request #(
        .WAYS (WAYS)
    ) process_request_u (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start),
        .req_i           (held_req),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .victim_way_i    (victim_way),
        .victim_dirty_i  (victim_dirty),
        .tags_i          (set_tags),
        .lines_i         (set_lines),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .out_busy_i      (mem_busy),
        .rd_en_o         (rd_en),
        .wr_en_o         (wr_en),
        .wr_way_o        (wr_way),
        .wr_tag_o        (wr_tag),
        .wr_state_o      (wr_state),
        .wr_data_o       (wr_data),
        .adv_evict_o     (adv_evict),
        .send_rsp_o      (send_rsp),
        .rsp_data_o      (rsp_data),
        .send_mem_o      (send_mem),
        .mem_req_o       (mem_req)
    );

    llc_output_regs output_regs_u (
        .clk             (clk),
        .rst             (rst),
        .send_rsp_i      (send_rsp),
        .rsp_data_i      (rsp_data),
        .send_mem_i      (send_mem),
        .mem_req_i       (mem_req),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_ready_i (mem_req_ready_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_data_o      (rsp_data_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_busy_o      (mem_busy),
        .rsp_done_o      (rsp_done)
    );

endmodule

// File: design/llc_input_decoder.sv
/* request intake
   takes one request while idle and holds it until its response is sent */
module llc_input_decoder
    import llc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid_i,
    input  llc_req_t req_i,
    output logic     req_ready_o,
    input  logic     done_i,
    output llc_req_t held_req_o,
    output logic     start_o
);

    logic busy;
    logic accept;

    assign req_ready_o = !busy;
    assign accept = req_valid_i && !busy;

    // busy from accept until the response transfer
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy    <= 1'b0;
            start_o <= 1'b0;
        end else begin
            start_o <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done_i) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_req_o <= req_i;
        end
    end

endmodule

// File: design/llc_lookup_way.sv
/* way lookup
   hit detection over the read set and victim choice for a miss */
module llc_lookup_way
    import llc_pkg::*;
#(
    parameter int WAYS = LLC_WAYS
) (
    input  llc_tag_t                    tag_i,
    input  llc_tag_t        [WAYS-1:0]  tags_i,
    input  llc_line_state_t [WAYS-1:0]  states_i,
    input  llc_way_t                    evict_way_i,
    output logic                        hit_o,
    output llc_way_t                    hit_way_o,
    output llc_way_t                    victim_way_o,
    output logic                        victim_dirty_o
);

    always_comb begin
        hit_o        = 1'b0;
        hit_way_o    = '0;
        victim_way_o = evict_way_i;

        // scan downward so the lowest invalid way wins
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (!states_i[i].valid) begin
                victim_way_o = llc_way_t'(i);
            end
        end

        for (int i = 0; i < WAYS; i++) begin
            if (states_i[i].valid && tags_i[i] == tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = llc_way_t'(i);
            end
        end

        victim_dirty_o = states_i[victim_way_o].valid && states_i[victim_way_o].dirty;
    end

endmodule

// File: design/llc_output_regs.sv
/* output holding registers
   response and memory request stay valid until taken */
module llc_output_regs
    import llc_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         send_rsp_i,
    input  llc_word_t    rsp_data_i,
    input  logic         send_mem_i,
    input  llc_mem_req_t mem_req_i,
    input  logic         rsp_ready_i,
    input  logic         mem_req_ready_i,
    output logic         rsp_valid_o,
    output llc_word_t    rsp_data_o,
    output logic         mem_req_valid_o,
    output llc_mem_req_t mem_req_o,
    output logic         mem_busy_o,
    output logic         rsp_done_o
);

    assign rsp_done_o = rsp_valid_o && rsp_ready_i;
    assign mem_busy_o = mem_req_valid_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_valid_o     <= 1'b0;
            mem_req_valid_o <= 1'b0;
        end else begin
            if (send_rsp_i) begin
                rsp_valid_o <= 1'b1;
            end else if (rsp_done_o) begin
                rsp_valid_o <= 1'b0;
            end
            if (send_mem_i) begin
                mem_req_valid_o <= 1'b1;
            end else if (mem_req_valid_o && mem_req_ready_i) begin
                mem_req_valid_o <= 1'b0;
            end
        end
    end

    // loaded only while the channel is idle
    always_ff @(posedge clk) begin
        if (send_rsp_i) begin
            rsp_data_o <= rsp_data_i;
        end
        if (send_mem_i) begin
            mem_req_o <= mem_req_i;
        end
    end

endmodule

// File: design/llc_pkg.sv
/* last-level cache shared types
   sizes, line address breakdown, request and line state definitions */
package llc_pkg;

    // cache geometry
    localparam int LLC_SETS      = 4;
    localparam int LLC_WAYS      = 2;
    localparam int LLC_WORD_BITS = 32;
    localparam int LLC_ADDR_BITS = 8;

    localparam int LLC_SET_BITS = $clog2(LLC_SETS);
    localparam int LLC_TAG_BITS = LLC_ADDR_BITS - LLC_SET_BITS;
    localparam int LLC_WAY_BITS = (LLC_WAYS > 1) ? $clog2(LLC_WAYS) : 1;

    typedef logic [LLC_WORD_BITS-1:0] llc_word_t;
    typedef logic [LLC_TAG_BITS-1:0]  llc_tag_t;
    typedef logic [LLC_SET_BITS-1:0]  llc_set_t;
    typedef logic [LLC_WAY_BITS-1:0]  llc_way_t;

    // set index sits in the low bits of the line address
    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } llc_addr_fields_t;

    typedef union packed {
        logic [LLC_ADDR_BITS-1:0] raw;
        llc_addr_fields_t         f;
    } llc_addr_u;

    // one request from the input channel
    typedef struct packed {
        logic      write;
        llc_addr_u addr;
        llc_word_t data;
    } llc_req_t;

    // memory side request, write-back or fill read
    typedef struct packed {
        logic                     write;
        logic [LLC_ADDR_BITS-1:0] addr;
        llc_word_t                data;
    } llc_mem_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } llc_line_state_t;

endpackage

// File: design/llc_process_request.sv
/* request control FSM
   set read, lookup, write-back of a dirty victim, fill, line update and response */
module llc_process_request
    import llc_pkg::*;
#(
    parameter int WAYS = LLC_WAYS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  llc_req_t               req_i,
    input  logic                   hit_i,
    input  llc_way_t               hit_way_i,
    input  llc_way_t               victim_way_i,
    input  logic                   victim_dirty_i,
    input  llc_tag_t   [WAYS-1:0]  tags_i,
    input  llc_word_t  [WAYS-1:0]  lines_i,
    input  logic                   mem_rsp_valid_i,
    input  llc_word_t              mem_rsp_data_i,
    output logic                   mem_rsp_ready_o,
    input  logic                   out_busy_i,
    output logic                   rd_en_o,
    output logic                   wr_en_o,
    output llc_way_t               wr_way_o,
    output llc_tag_t               wr_tag_o,
    output llc_line_state_t        wr_state_o,
    output llc_word_t              wr_data_o,
    output logic                   adv_evict_o,
    output logic                   send_rsp_o,
    output llc_word_t              rsp_data_o,
    output logic                   send_mem_o,
    output llc_mem_req_t           mem_req_o
);

    localparam logic [2:0] S_READ_SET   = 3'd0;
    localparam logic [2:0] S_LOOKUP     = 3'd1;
    localparam logic [2:0] S_WRITE_BACK = 3'd2;
    localparam logic [2:0] S_FILL_REQ   = 3'd3;
    localparam logic [2:0] S_FILL_WAIT  = 3'd4;
    localparam logic [2:0] S_UPDATE     = 3'd5;

    logic [2:0] state;
    logic [2:0] next_state;
    logic       hit_q;
    llc_way_t   way_q;
    llc_word_t  fill_q;
    llc_addr_u  wb_addr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= S_READ_SET;
            hit_q <= 1'b0;
            way_q <= '0;
        end else begin
            state <= next_state;
            // way to update: hit way, or victim on a miss
            if (state == S_LOOKUP) begin
                hit_q <= hit_i;
                way_q <= hit_i ? hit_way_i : victim_way_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FILL_WAIT && mem_rsp_valid_i) begin
            fill_q <= mem_rsp_data_i;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_READ_SET: begin
                if (start_i) begin
                    next_state = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit_i) begin
                    next_state = S_UPDATE;
                end else if (victim_dirty_i) begin
                    next_state = S_WRITE_BACK;
                end else begin
                    next_state = S_FILL_REQ;
                end
            end
            S_WRITE_BACK: begin
                if (!out_busy_i) begin
                    next_state = S_FILL_REQ;
                end
            end
            S_FILL_REQ: begin
                if (!out_busy_i) begin
                    next_state = S_FILL_WAIT;
                end
            end
            S_FILL_WAIT: begin
                if (mem_rsp_valid_i) begin
                    next_state = S_UPDATE;
                end
            end
            S_UPDATE: begin
                next_state = S_READ_SET;
            end
            default: begin
                next_state = S_READ_SET;
            end
        endcase
    end

    // set index comes from the held request
    assign rd_en_o = (state == S_READ_SET) && start_i;

    // victim goes back at its own tag in the same set
    always_comb begin
        wb_addr.f.tag = tags_i[way_q];
        wb_addr.f.set = req_i.addr.f.set;
    end

    assign send_mem_o = ((state == S_WRITE_BACK) || (state == S_FILL_REQ)) && !out_busy_i;

    always_comb begin
        if (state == S_WRITE_BACK) begin
            mem_req_o.write = 1'b1;
            mem_req_o.addr  = wb_addr.raw;
            mem_req_o.data  = lines_i[way_q];
        end else begin
            mem_req_o.write = 1'b0;
            mem_req_o.addr  = req_i.addr.raw;
            mem_req_o.data  = '0;
        end
    end

    assign mem_rsp_ready_o = (state == S_FILL_WAIT);

    // a read hit leaves the line untouched so its dirty bit survives
    assign wr_en_o          = (state == S_UPDATE) && (req_i.write || !hit_q);
    assign wr_way_o         = way_q;
    assign wr_tag_o         = req_i.addr.f.tag;
    assign wr_state_o.valid = 1'b1;
    assign wr_state_o.dirty = req_i.write;
    assign wr_data_o        = req_i.write ? req_i.data : fill_q;
    assign adv_evict_o      = (state == S_UPDATE) && !hit_q;

    assign send_rsp_o = (state == S_UPDATE);

    always_comb begin
        if (req_i.write) begin
            rsp_data_o = req_i.data;
        end else if (hit_q) begin
            rsp_data_o = lines_i[way_q];
        end else begin
            rsp_data_o = fill_q;
        end
    end

endmodule

// File: design/llc_tag_store.sv
/* tag, state and data arrays of the cache
   whole-set registered read, single-way write, round-robin evict pointer per set */
module llc_tag_store
    import llc_pkg::*;
#(
    parameter int SETS = LLC_SETS,
    parameter int WAYS = LLC_WAYS
) (
    input  logic                        clk,
    input  logic                        rst,
    input  llc_set_t                    rd_set_i,
    input  logic                        rd_en_i,
    input  logic                        wr_en_i,
    input  llc_way_t                    wr_way_i,
    input  llc_tag_t                    wr_tag_i,
    input  llc_line_state_t             wr_state_i,
    input  llc_word_t                   wr_data_i,
    input  logic                        adv_evict_i,
    output llc_tag_t        [WAYS-1:0]  tags_o,
    output llc_line_state_t [WAYS-1:0]  states_o,
    output llc_word_t       [WAYS-1:0]  lines_o,
    output llc_way_t                    evict_way_o
);

    llc_tag_t        tag_mem   [SETS][WAYS];
    llc_word_t       data_mem  [SETS][WAYS];
    llc_line_state_t state_mem [SETS][WAYS];
    llc_way_t        evict_ptr [SETS];

    // line state and evict pointers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                evict_ptr[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    state_mem[s][w] <= '0;
                end
            end
        end else begin
            if (wr_en_i) begin
                state_mem[rd_set_i][wr_way_i] <= wr_state_i;
            end
            if (adv_evict_i) begin
                if (evict_ptr[rd_set_i] == llc_way_t'(WAYS - 1)) begin
                    evict_ptr[rd_set_i] <= '0;
                end else begin
                    evict_ptr[rd_set_i] <= evict_ptr[rd_set_i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[rd_set_i][wr_way_i]  <= wr_tag_i;
            data_mem[rd_set_i][wr_way_i] <= wr_data_i;
        end
    end

    // whole set read, held until the next read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < WAYS; w++) begin
                tags_o[w]   <= tag_mem[rd_set_i][w];
                states_o[w] <= state_mem[rd_set_i][w];
                lines_o[w]  <= data_mem[rd_set_i][w];
            end
            evict_way_o <= evict_ptr[rd_set_i];
        end
    end

endmodule

// File: tests/llc_core_asserts.sv
/* handshake checks bound to the cache core
   outputs hold until taken, idle after reset, no new request while a response waits */
module llc_core_asserts
    import llc_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         req_ready_o,
    input logic         rsp_valid_o,
    input logic         rsp_ready_i,
    input llc_word_t    rsp_data_o,
    input logic         mem_req_valid_o,
    input logic         mem_req_ready_i,
    input llc_mem_req_t mem_req_o
);

    rsp_held: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
        else $error("response valid dropped or data changed before ready");

    mem_req_held: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else $error("memory request valid dropped or changed before ready");

    // first edge out of reset
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> !rsp_valid_o && !mem_req_valid_o)
        else $error("output valid high right after reset");

    no_accept_while_pending: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o |-> !req_ready_o)
        else $error("request ready while a response is pending");

endmodule

bind llc_core llc_core_asserts core_asserts_u (
    .clk             (clk),
    .rst             (rst),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_data_o      (rsp_data_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o)
);

// File: tests/llc_patterns.hex
// columns: op (0 read, 1 write), line address, write data, expected response, flags
// flags: bit 0 one memory read at the address, bit 1 one dirty write-back before it
0 10 00000000 A5000010 1
0 10 00000000 A5000010 0
1 10 11111111 11111111 0
0 10 00000000 11111111 0
1 24 22222222 22222222 1
0 30 00000000 A5000030 3
0 10 00000000 11111111 3
0 24 00000000 22222222 1
0 10 00000000 11111111 0
0 01 00000000 A5000001 1
1 05 33333333 33333333 1
1 01 44444444 44444444 0
0 05 00000000 33333333 0
0 09 00000000 A5000009 3
0 01 00000000 44444444 3
0 FF 00000000 A50000FF 1
// random back-pressure on both outputs from here on
1 02 55555555 55555555 1
1 06 66666666 66666666 1
1 0A 77777777 77777777 3
0 06 00000000 66666666 0
0 02 00000000 55555555 3
0 06 00000000 66666666 3
0 0A 00000000 77777777 1
0 FF 00000000 A50000FF 0
1 7F 88888888 88888888 1
1 FF 99999999 99999999 0
0 3F 00000000 A500003F 3
0 FF 00000000 99999999 3
0 7F 00000000 88888888 1
0 24 00000000 22222222 0

// File: tests/llc_tb.sv
/* testbench for the last-level cache core
   pattern-driven requests, memory model with random delay, random back-pressure */
module llc_tb
    import llc_pkg::*;
();

    localparam int NUM_TESTS   = 30;
    localparam int BP_FROM     = 17;
    localparam int HIT_LATENCY = 3;

    logic         clk;
    logic         rst;
    logic         req_valid_i;
    llc_req_t     req_i;
    logic         req_ready_o;
    logic         rsp_valid_o;
    logic         rsp_ready_i;
    llc_word_t    rsp_data_o;
    logic         mem_req_valid_o;
    logic         mem_req_ready_i;
    llc_mem_req_t mem_req_o;
    logic         mem_rsp_valid_i;
    llc_word_t    mem_rsp_data_i;
    logic         mem_rsp_ready_o;

    logic [31:0]              patterns [NUM_TESTS*5];
    llc_word_t                mem_model [2**LLC_ADDR_BITS];
    llc_word_t                rsp_q [$];
    logic [31:0]              rnd_state;
    int                       cycle;
    int                       errors;
    int                       rd_count;
    int                       wb_count;
    int                       rsp_rise_cycle;
    logic                     rsp_rise_seen;
    logic                     bp_en;
    logic [LLC_ADDR_BITS-1:0] cur_addr;
    logic                     rd_pending;
    logic [LLC_ADDR_BITS-1:0] rd_addr;
    int                       rd_delay;
    logic                     mem_rsp_go;
    logic                     fill_open;

    llc_core #(
        .SETS (LLC_SETS),
        .WAYS (LLC_WAYS)
    ) UUT (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_data_o      (rsp_data_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic send_request(input logic write, input logic [LLC_ADDR_BITS-1:0] addr,
                                input llc_word_t data, output int accept_edge);
        @(negedge clk);
        req_valid_i    = 1'b1;
        req_i.write    = write;
        req_i.addr.raw = addr;
        req_i.data     = data;
        while (!req_ready_o) begin
            @(negedge clk);
        end
        // taken at the coming rising edge
        accept_edge = cycle + 1;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // memory model, ready toggling and response monitor
    always @(negedge clk) begin
        if (mem_rsp_go) begin
            mem_rsp_valid_i = 1'b0;
            mem_rsp_go      = 1'b0;
        end
        if (rd_pending) begin
            if (rd_delay == 0) begin
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i  = mem_model[rd_addr];
                rd_pending      = 1'b0;
            end else begin
                rd_delay--;
            end
        end
        mem_rsp_go = mem_rsp_valid_i && mem_rsp_ready_o;

        rnd_state       = xorshift32(rnd_state);
        mem_req_ready_i = bp_en ? rnd_state[3] : 1'b1;
        rsp_ready_i     = bp_en ? rnd_state[9] : 1'b1;

        // request moves at the next rising edge
        if (mem_req_valid_o && mem_req_ready_i) begin
            if (mem_req_o.write) begin
                mem_model[mem_req_o.addr] = mem_req_o.data;
                wb_count++;
            end else begin
                check_value("mem_req_o.addr", 32'(mem_req_o.addr), 32'(cur_addr));
                rd_count++;
                rd_pending = 1'b1;
                rd_addr    = mem_req_o.addr;
                rd_delay   = int'(rnd_state[17:16]);
            end
        end

        // fill data is taken only while a fill read is open
        fill_open = rd_pending || mem_rsp_valid_i || (mem_req_valid_o && !mem_req_o.write);
        check_value("mem_rsp_ready_o", 32'(mem_rsp_ready_o), 32'(fill_open));

        if (rsp_valid_o && !rsp_rise_seen) begin
            rsp_rise_seen  = 1'b1;
            rsp_rise_cycle = cycle;
        end
        if (rsp_valid_o && rsp_ready_i) begin
            rsp_q.push_back(rsp_data_o);
            rsp_rise_seen = 1'b0;
        end
    end

    initial begin
        logic [31:0] op;
        logic [31:0] addr_w;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic [31:0] flags;
        llc_word_t   got;
        int          accept_edge;
        int          err_before;
        int          rd_before;
        int          wb_before;
        int          passed;

        clk             = 1'b0;
        rst             = 1'b0;
        req_valid_i     = 1'b0;
        req_i           = '0;
        rsp_ready_i     = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        rnd_state       = 32'd4473;
        cycle           = 0;
        errors          = 0;
        rd_count        = 0;
        wb_count        = 0;
        rsp_rise_cycle  = 0;
        rsp_rise_seen   = 1'b0;
        bp_en           = 1'b0;
        cur_addr        = '0;
        rd_pending      = 1'b0;
        rd_addr         = '0;
        rd_delay        = 0;
        mem_rsp_go      = 1'b0;
        fill_open       = 1'b0;
        passed          = 0;
        for (int a = 0; a < 2**LLC_ADDR_BITS; a++) begin
            mem_model[a] = 32'hA500_0000 + 32'(a);
        end
        $readmemh("tests/llc_patterns.hex", patterns);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
        check_value("mem_req_valid_o", 32'(mem_req_valid_o), 32'd0);
        check_value("req_ready_o", 32'(req_ready_o), 32'd1);
        $display("test 0: reset state -> %s", (errors == 0) ? "pass" : "FAIL");
        if (errors == 0) begin
            passed++;
        end
        @(posedge clk);

        for (int t = 0; t < NUM_TESTS; t++) begin
            op       = patterns[t*5];
            addr_w   = patterns[t*5+1];
            wdata    = patterns[t*5+2];
            exp_data = patterns[t*5+3];
            flags    = patterns[t*5+4];
            bp_en      = (t + 1 >= BP_FROM);
            cur_addr   = addr_w[LLC_ADDR_BITS-1:0];
            err_before = errors;
            rd_before  = rd_count;
            wb_before  = wb_count;

            send_request(op[0], addr_w[LLC_ADDR_BITS-1:0], wdata, accept_edge);
            do begin
                @(posedge clk);
            end while (rsp_q.size() == 0);
            got = rsp_q.pop_front();

            check_value("rsp_data_o", got, exp_data);
            check_value("mem reads", 32'(rd_count - rd_before), {31'b0, flags[0]});
            check_value("mem write-backs", 32'(wb_count - wb_before), {31'b0, flags[1]});
            if (flags == 0) begin
                check_value("hit latency", 32'(rsp_rise_cycle - accept_edge), HIT_LATENCY);
            end

            if (errors == err_before) begin
                passed++;
            end
            $display("test %0d: %s addr %h rsp %h -> %s", t + 1,
                     op[0] ? "write" : "read ", addr_w[LLC_ADDR_BITS-1:0], got,
                     (errors == err_before) ? "pass" : "FAIL");
        end

        // nothing more may arrive once the last request is answered
        repeat (20) @(posedge clk);
        check_value("extra responses", 32'(rsp_q.size()), 32'd0);

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 NUM_TESTS + 1, passed, NUM_TESTS + 1 - passed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", NUM_TESTS * 200);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verilog.f
design/llc_pkg.sv
design/llc_input_decoder.sv
design/llc_tag_store.sv
design/llc_lookup_way.sv
design/llc_process_request.sv
design/llc_output_regs.sv
design/llc_core.sv
tests/llc_core_asserts.sv
tests/llc_tb.sv
